// File: common/periph_pkg.sv
// Shared bus structs, response codes and register offsets; imported by every harness module
package periph_pkg;

    // ============================================================
    // Single-beat load/store bus
    // ============================================================

    // One access, merged address and data channels
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        write;
    } lite_req_t;

    // Read data plus status, also used as write ack
    typedef struct packed {
        logic [31:0] rdata;
        logic [1:0]  resp;
    } lite_rsp_t;

    // AXI style status codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // ============================================================
    // Register maps, offsets from each block's base
    // ============================================================

    // CLINT, high words sit at +4
    localparam logic [31:0] CLINT_MSIP_OFS     = 32'h0000_0000;
    localparam logic [31:0] CLINT_MTIMECMP_OFS = 32'h0000_4000;
    localparam logic [31:0] CLINT_MTIME_OFS    = 32'h0000_BFF8;

    // PLIC
    localparam logic [31:0] PLIC_ENABLE_OFS  = 32'h0000_0000;
    localparam logic [31:0] PLIC_PENDING_OFS = 32'h0000_0004;
    localparam logic [31:0] PLIC_CLAIM_OFS   = 32'h0000_0008;

    // Byte-lane merge for strobed register writes
    function automatic logic [31:0] strb_merge(
        input logic [31:0] old_word,
        input logic [31:0] wdata,
        input logic [3:0]  wstrb
    );
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            // Only lanes with strobe set take new data
            if (wstrb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: xbar/lite_xbar.sv
// Single-master crossbar; decodes each access and routes it to RAM, CLINT, PLIC or a decode error
module lite_xbar import periph_pkg::*; #(
    parameter logic [31:0] CLINT_BASE = 32'h0000_3000,
    parameter logic [31:0] PLIC_BASE  = 32'h0000_F000
) (
    input  logic      clk,
    input  logic      reset,
    // Master side
    input  logic      cpu_req_valid,
    input  lite_req_t cpu_req,
    output logic      cpu_req_ready,
    output logic      cpu_rsp_valid,
    output lite_rsp_t cpu_rsp,
    input  logic      cpu_rsp_ready,
    // External RAM
    output logic      ram_req_valid,
    output lite_req_t ram_req,
    input  logic      ram_req_ready,
    input  logic      ram_rsp_valid,
    input  lite_rsp_t ram_rsp,
    output logic      ram_rsp_ready,
    // Peripheral strobes
    output logic      clint_sel,
    output logic      plic_sel,
    output lite_req_t periph_req,
    input  lite_rsp_t clint_rsp,
    input  lite_rsp_t plic_rsp,
    input  logic      clint_rsp_valid,
    input  logic      plic_rsp_valid
);

    typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_WAIT, ST_RESP} state_t;
    typedef enum logic [1:0] {TGT_RAM, TGT_CLINT, TGT_PLIC, TGT_ERR} tgt_t;

    state_t    state_q;
    tgt_t      tgt_q;
    lite_req_t req_q;
    lite_rsp_t rsp_q;
    lite_rsp_t rsp_n;
    logic      rsp_done;

    // Address map, RAM also covers the upper half
    function automatic tgt_t decode(input logic [31:0] addr);
        tgt_t tgt;
        if (addr < CLINT_BASE || addr >= 32'h8000_0000) begin
            tgt = TGT_RAM;
        end else if (addr < PLIC_BASE) begin
            tgt = TGT_CLINT;
        end else if (addr <= 32'h0000_FFFF) begin
            tgt = TGT_PLIC;
        end else begin
            tgt = TGT_ERR;
        end
        return tgt;
    endfunction

    // ============================================================
    // Request decode
    // ============================================================

    // One transaction in flight, so ready only when idle
    assign cpu_req_ready = (state_q == ST_IDLE);

    // Latch request and target on acceptance
    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_q <= cpu_req;
            tgt_q <= decode(cpu_req.addr);
        end
    end

    // RAM sees the address unchanged
    assign ram_req       = req_q;
    assign ram_req_valid = (state_q == ST_FWD) && (tgt_q == TGT_RAM);
    assign ram_rsp_ready = (state_q == ST_WAIT) && (tgt_q == TGT_RAM);

    // One-cycle strobes in FWD
    assign clint_sel = (state_q == ST_FWD) && (tgt_q == TGT_CLINT);
    assign plic_sel  = (state_q == ST_FWD) && (tgt_q == TGT_PLIC);

    // Peripherals get a base-relative offset
    always_comb begin
        periph_req = req_q;
        if (tgt_q == TGT_PLIC) begin
            periph_req.addr = req_q.addr - PLIC_BASE;
        end else begin
            periph_req.addr = req_q.addr - CLINT_BASE;
        end
    end

    // ============================================================
    // Response return
    // ============================================================

    // Pick the response of the selected target
    always_comb begin
        rsp_done = 1'b0;
        rsp_n    = '{rdata: 32'h0, resp: RESP_DECERR};
        case (tgt_q)
            TGT_RAM: begin
                rsp_done = ram_rsp_valid;
                rsp_n    = ram_rsp;
            end
            TGT_CLINT: begin
                rsp_done = clint_rsp_valid;
                rsp_n    = clint_rsp;
            end
            TGT_PLIC: begin
                rsp_done = plic_rsp_valid;
                rsp_n    = plic_rsp;
            end
            // Unmapped, answer locally
            default: rsp_done = 1'b1;
        endcase
    end

    // Held until the master takes it
    always_ff @(posedge clk) begin
        if (state_q == ST_WAIT && rsp_done) begin
            rsp_q <= rsp_n;
        end
    end

    assign cpu_rsp_valid = (state_q == ST_RESP);
    assign cpu_rsp       = rsp_q;

    // Transaction FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (cpu_req_valid) state_q <= ST_FWD;
                // RAM may stall the request, peripherals never do
                ST_FWD:  if (tgt_q != TGT_RAM || ram_req_ready) state_q <= ST_WAIT;
                ST_WAIT: if (rsp_done) state_q <= ST_RESP;
                ST_RESP: if (cpu_rsp_ready) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // RAM request held until accepted
    a_ram_req_stable: assert property (@(posedge clk) disable iff (reset)
        ram_req_valid && !ram_req_ready |=> ram_req_valid && $stable(ram_req));

    // At most one peripheral strobed or answering
    a_sel_onehot: assert property (@(posedge clk) disable iff (reset)
        !(clint_sel && plic_sel) && !(clint_rsp_valid && plic_rsp_valid));

endmodule

// File: clint/irq_clint.sv
// Core-local interruptor; machine timer, timer compare and software interrupt for the harness
module irq_clint import periph_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      sel,
    input  lite_req_t req,
    output lite_rsp_t rsp,
    output logic      rsp_valid,
    output logic      timer_irq,
    output logic      soft_irq
);

    logic        msip_q;
    logic [63:0] mtime_q;
    logic [63:0] mtime_n;
    logic [63:0] mtimecmp_q;
    logic [31:0] rdata_n;
    logic        wr_en;

    assign wr_en = sel && req.write;

    // ============================================================
    // Timer
    // ============================================================

    // Free-running count, a write overrides the addressed word
    always_comb begin
        mtime_n = mtime_q + 64'd1;
        if (wr_en && req.addr == CLINT_MTIME_OFS) begin
            mtime_n[31:0] = strb_merge(mtime_q[31:0], req.wdata, req.wstrb);
        end
        if (wr_en && req.addr == CLINT_MTIME_OFS + 32'd4) begin
            mtime_n[63:32] = strb_merge(mtime_q[63:32], req.wdata, req.wstrb);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime_q    <= 64'h0;
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
            timer_irq  <= 1'b0;
        end else begin
            mtime_q   <= mtime_n;
            // Registered compare
            timer_irq <= (mtime_q >= mtimecmp_q);
            if (wr_en && req.addr == CLINT_MTIMECMP_OFS) begin
                mtimecmp_q[31:0] <= strb_merge(mtimecmp_q[31:0], req.wdata, req.wstrb);
            end
            if (wr_en && req.addr == CLINT_MTIMECMP_OFS + 32'd4) begin
                mtimecmp_q[63:32] <= strb_merge(mtimecmp_q[63:32], req.wdata, req.wstrb);
            end
            // Only bit 0 of msip is implemented
            if (wr_en && req.addr == CLINT_MSIP_OFS && req.wstrb[0]) begin
                msip_q <= req.wdata[0];
            end
        end
    end

    assign soft_irq = msip_q;

    // ============================================================
    // Register read
    // ============================================================

    // Unmapped offsets read as zero
    always_comb begin
        case (req.addr)
            CLINT_MSIP_OFS:             rdata_n = {31'h0, msip_q};
            CLINT_MTIMECMP_OFS:         rdata_n = mtimecmp_q[31:0];
            CLINT_MTIMECMP_OFS + 32'd4: rdata_n = mtimecmp_q[63:32];
            CLINT_MTIME_OFS:            rdata_n = mtime_q[31:0];
            CLINT_MTIME_OFS + 32'd4:    rdata_n = mtime_q[63:32];
            default:                    rdata_n = 32'h0;
        endcase
    end

    // Response one cycle after the strobe
    always_ff @(posedge clk) begin
        if (sel) begin
            rsp.rdata <= req.write ? 32'h0 : rdata_n;
            rsp.resp  <= RESP_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel;
        end
    end

    // Every response answers a lone strobe with no new strobe on top
    a_rsp_after_sel: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> $past(sel) && !sel);

endmodule

// File: plic/irq_plic.sv
// Platform interrupt controller; level gateways, enables and claim/complete for the harness
module irq_plic import periph_pkg::*; #(
    parameter int NUM_IRQS = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [NUM_IRQS-1:0] irq_in,
    input  logic                sel,
    input  lite_req_t           req,
    output lite_rsp_t           rsp,
    output logic                rsp_valid,
    output logic                ext_irq
);

    logic [NUM_IRQS-1:0] pending_q;
    logic [NUM_IRQS-1:0] pending_n;
    logic [NUM_IRQS-1:0] inflight_q;
    logic [NUM_IRQS-1:0] inflight_n;
    logic [NUM_IRQS-1:0] enable_q;
    logic [NUM_IRQS-1:0] claim_mask;
    logic [31:0]         claim_id;
    logic [31:0]         enable_word;
    logic [31:0]         rdata_n;
    logic                claim_rd;
    logic                claim_wr;

    assign claim_rd    = sel && !req.write && req.addr == PLIC_CLAIM_OFS;
    assign claim_wr    = sel && req.write && req.addr == PLIC_CLAIM_OFS;
    assign enable_word = 32'(enable_q);

    // ============================================================
    // Claim arbitration
    // ============================================================

    // Lowest source number wins, so scan downward
    always_comb begin
        claim_id   = 32'h0;
        claim_mask = '0;
        for (int i = NUM_IRQS - 1; i >= 0; i--) begin
            if (pending_q[i] && enable_q[i]) begin
                claim_id   = 32'(i + 1);
                claim_mask = NUM_IRQS'(1) << i;
            end
        end
    end

    // ============================================================
    // Gateways
    // ============================================================

    always_comb begin
        // Level lines latch while the source is idle
        pending_n  = pending_q | (irq_in & ~inflight_q);
        inflight_n = inflight_q;
        if (claim_rd) begin
            pending_n  = pending_n & ~claim_mask;
            inflight_n = inflight_n | claim_mask;
        end
        // Complete by writing the source id
        if (claim_wr) begin
            for (int i = 0; i < NUM_IRQS; i++) begin
                if (req.wdata == 32'(i + 1)) begin
                    inflight_n[i] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q  <= '0;
            inflight_q <= '0;
            enable_q   <= '0;
            ext_irq    <= 1'b0;
        end else begin
            pending_q  <= pending_n;
            inflight_q <= inflight_n;
            ext_irq    <= |(pending_q & enable_q);
            if (sel && req.write && req.addr == PLIC_ENABLE_OFS) begin
                enable_q <= NUM_IRQS'(strb_merge(enable_word, req.wdata, req.wstrb));
            end
        end
    end

    // ============================================================
    // Register read
    // ============================================================

    always_comb begin
        case (req.addr)
            PLIC_ENABLE_OFS:  rdata_n = enable_word;
            PLIC_PENDING_OFS: rdata_n = 32'(pending_q);
            PLIC_CLAIM_OFS:   rdata_n = claim_id;
            default:          rdata_n = 32'h0;
        endcase
    end

    // Registered response, one cycle after sel
    always_ff @(posedge clk) begin
        if (sel) begin
            rsp.rdata <= req.write ? 32'h0 : rdata_n;
            rsp.resp  <= RESP_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel;
        end
    end

    // Gateway holds a source in one stage only
    a_pending_vs_inflight: assert property (@(posedge clk) disable iff (reset)
        (pending_q & inflight_q) == '0);

endmodule

// File: src/periph_harness.sv
// Top of the peripheral harness; ties crossbar, CLINT and PLIC to the master, RAM and irq ports
module periph_harness import periph_pkg::*; #(
    parameter int          NUM_IRQS   = 5,
    parameter logic [31:0] CLINT_BASE = 32'h0000_3000,
    parameter logic [31:0] PLIC_BASE  = 32'h0000_F000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [NUM_IRQS-1:0] irq_in,
    // Load/store master
    input  logic                cpu_req_valid,
    input  lite_req_t           cpu_req,
    output logic                cpu_req_ready,
    output logic                cpu_rsp_valid,
    output lite_rsp_t           cpu_rsp,
    input  logic                cpu_rsp_ready,
    // External RAM
    output logic                ram_req_valid,
    output lite_req_t           ram_req,
    input  logic                ram_req_ready,
    input  logic                ram_rsp_valid,
    input  lite_rsp_t           ram_rsp,
    output logic                ram_rsp_ready,
    // Interrupts to the core
    output logic                timer_irq,
    output logic                soft_irq,
    output logic                ext_irq
);

    // ============================================================
    // Crossbar to peripheral strobes
    // ============================================================

    logic      clint_sel;
    logic      plic_sel;
    lite_req_t periph_req;
    lite_rsp_t clint_rsp;
    lite_rsp_t plic_rsp;
    logic      clint_rsp_valid;
    logic      plic_rsp_valid;

    lite_xbar #(
        .CLINT_BASE (CLINT_BASE),
        .PLIC_BASE  (PLIC_BASE)
    ) u_xbar (
        .clk             (clk),
        .reset           (reset),
        .cpu_req_valid   (cpu_req_valid),
        .cpu_req         (cpu_req),
        .cpu_req_ready   (cpu_req_ready),
        .cpu_rsp_valid   (cpu_rsp_valid),
        .cpu_rsp         (cpu_rsp),
        .cpu_rsp_ready   (cpu_rsp_ready),
        .ram_req_valid   (ram_req_valid),
        .ram_req         (ram_req),
        .ram_req_ready   (ram_req_ready),
        .ram_rsp_valid   (ram_rsp_valid),
        .ram_rsp         (ram_rsp),
        .ram_rsp_ready   (ram_rsp_ready),
        .clint_sel       (clint_sel),
        .plic_sel        (plic_sel),
        .periph_req      (periph_req),
        .clint_rsp       (clint_rsp),
        .plic_rsp        (plic_rsp),
        .clint_rsp_valid (clint_rsp_valid),
        .plic_rsp_valid  (plic_rsp_valid)
    );

    // Timer and software interrupt
    irq_clint u_clint (
        .clk       (clk),
        .reset     (reset),
        .sel       (clint_sel),
        .req       (periph_req),
        .rsp       (clint_rsp),
        .rsp_valid (clint_rsp_valid),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    // External interrupt lines
    irq_plic #(
        .NUM_IRQS (NUM_IRQS)
    ) u_plic (
        .clk       (clk),
        .reset     (reset),
        .irq_in    (irq_in),
        .sel       (plic_sel),
        .req       (periph_req),
        .rsp       (plic_rsp),
        .rsp_valid (plic_rsp_valid),
        .ext_irq   (ext_irq)
    );

endmodule

// File: bench/periph_harness_tb.sv
// Testbench for the peripheral harness; runs a table of bus accesses against a RAM model
module periph_harness_tb import periph_pkg::*; ();

    localparam int          NUM_IRQS   = 5;
    localparam logic [31:0] CLINT_BASE = 32'h0000_3000;
    localparam logic [31:0] PLIC_BASE  = 32'h0000_F000;
    localparam logic [31:0] RAM_XOR    = 32'hA5A5_A5A5;
    localparam int          WAIT_LIMIT = 2000;

    // Absolute register addresses
    localparam logic [31:0] MSIP     = CLINT_BASE + CLINT_MSIP_OFS;
    localparam logic [31:0] CMP_LO   = CLINT_BASE + CLINT_MTIMECMP_OFS;
    localparam logic [31:0] CMP_HI   = CLINT_BASE + CLINT_MTIMECMP_OFS + 32'd4;
    localparam logic [31:0] P_ENABLE = PLIC_BASE + PLIC_ENABLE_OFS;
    localparam logic [31:0] P_PEND   = PLIC_BASE + PLIC_PENDING_OFS;
    localparam logic [31:0] P_CLAIM  = PLIC_BASE + PLIC_CLAIM_OFS;

    // Wait ops poll one interrupt until it matches exp_rdata[0]
    typedef enum logic [2:0] {OP_RD, OP_WR, OP_WAIT_TIMER, OP_WAIT_SOFT, OP_WAIT_EXT} op_t;

    typedef struct packed {
        op_t                 op;
        logic [31:0]         addr;
        logic [31:0]         wdata;
        logic [3:0]          wstrb;
        logic [31:0]         exp_rdata;
        logic [1:0]          exp_resp;
        logic [NUM_IRQS-1:0] irq;
    } step_t;

    logic                clk;
    logic                reset;
    logic [NUM_IRQS-1:0] irq_in;
    logic                cpu_req_valid;
    lite_req_t           cpu_req;
    logic                cpu_req_ready;
    logic                cpu_rsp_valid;
    lite_rsp_t           cpu_rsp;
    logic                cpu_rsp_ready;
    logic                ram_req_valid;
    lite_req_t           ram_req;
    logic                ram_req_ready;
    logic                ram_rsp_valid;
    lite_rsp_t           ram_rsp;
    logic                ram_rsp_ready;
    logic                timer_irq;
    logic                soft_irq;
    logic                ext_irq;

    step_t       steps[$];
    logic [31:0] lfsr_state = 32'hf4ec_3b37;
    int          errors;
    int          timeouts;
    int          ram_count;
    lite_req_t   ram_seen;

    periph_harness #(
        .NUM_IRQS   (NUM_IRQS),
        .CLINT_BASE (CLINT_BASE),
        .PLIC_BASE  (PLIC_BASE)
    ) DUT (.*);

    always #20 clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Address map rule for the external port
    function automatic logic maps_to_ram(input logic [31:0] addr);
        return addr <= 32'h0000_2FFF || addr >= 32'h8000_0000;
    endfunction

    function automatic logic irq_level(input op_t op);
        case (op)
            OP_WAIT_TIMER: return timer_irq;
            OP_WAIT_SOFT:  return soft_irq;
            default:       return ext_irq;
        endcase
    endfunction

    task automatic add_step(input op_t op, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic [31:0] exp_rdata,
                            input logic [1:0] exp_resp, input logic [NUM_IRQS-1:0] irq);
        step_t s;
        s = '{op, addr, wdata, wstrb, exp_rdata, exp_resp, irq};
        steps.push_back(s);
    endtask

    // ============================================================
    // Stimulus table
    // ============================================================

    task automatic build_table();
        // RAM window low and high, then unmapped holes
        add_step(OP_RD, 32'h0000_0100, 32'h0, 4'h0, 32'h0000_0100 ^ RAM_XOR, RESP_OKAY, 5'h00);
        add_step(OP_WR, 32'h0000_0200, 32'h1234_5678, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_RD, 32'h0000_2FFC, 32'h0, 4'h0, 32'h0000_2FFC ^ RAM_XOR, RESP_OKAY, 5'h00);
        add_step(OP_RD, 32'h8000_0010, 32'h0, 4'h0, 32'h8000_0010 ^ RAM_XOR, RESP_OKAY, 5'h00);
        add_step(OP_WR, 32'hFFFF_FFF0, 32'hDEAD_BEEF, 4'h3, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_RD, 32'h0001_0000, 32'h0, 4'h0, 32'h0, RESP_DECERR, 5'h00);
        add_step(OP_WR, 32'h0001_0000, 32'h5555_AAAA, 4'hF, 32'h0, RESP_DECERR, 5'h00);
        add_step(OP_RD, 32'h7FFF_FFFC, 32'h0, 4'h0, 32'h0, RESP_DECERR, 5'h00);
        // Software interrupt on and off
        add_step(OP_WR, MSIP, 32'h1, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_WAIT_SOFT, 32'h0, 32'h0, 4'h0, 32'h1, RESP_OKAY, 5'h00);
        add_step(OP_RD, MSIP, 32'h0, 4'h0, 32'h1, RESP_OKAY, 5'h00);
        add_step(OP_WR, MSIP, 32'h0, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_WAIT_SOFT, 32'h0, 32'h0, 4'h0, 32'h0, RESP_OKAY, 5'h00);
        // Small compare value, then back to all ones
        add_step(OP_WR, CMP_HI, 32'h0, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_WR, CMP_LO, 32'h200, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_RD, CMP_LO, 32'h0, 4'h0, 32'h200, RESP_OKAY, 5'h00);
        add_step(OP_WAIT_TIMER, 32'h0, 32'h0, 4'h0, 32'h1, RESP_OKAY, 5'h00);
        add_step(OP_WR, CMP_LO, 32'hFFFF_FFFF, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_WR, CMP_HI, 32'hFFFF_FFFF, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_WAIT_TIMER, 32'h0, 32'h0, 4'h0, 32'h0, RESP_OKAY, 5'h00);
        // Sources 2 and 4 on lines 1 and 3
        add_step(OP_WR, P_ENABLE, 32'h0A, 4'hF, 32'h0, RESP_OKAY, 5'h0A);
        add_step(OP_WAIT_EXT, 32'h0, 32'h0, 4'h0, 32'h1, RESP_OKAY, 5'h0A);
        add_step(OP_RD, P_PEND, 32'h0, 4'h0, 32'h0A, RESP_OKAY, 5'h0A);
        add_step(OP_RD, P_CLAIM, 32'h0, 4'h0, 32'd2, RESP_OKAY, 5'h0A);
        add_step(OP_WR, P_CLAIM, 32'd2, 4'hF, 32'h0, RESP_OKAY, 5'h08);
        add_step(OP_RD, P_CLAIM, 32'h0, 4'h0, 32'd4, RESP_OKAY, 5'h08);
        add_step(OP_WR, P_CLAIM, 32'd4, 4'hF, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_WAIT_EXT, 32'h0, 32'h0, 4'h0, 32'h0, RESP_OKAY, 5'h00);
        add_step(OP_RD, P_CLAIM, 32'h0, 4'h0, 32'd0, RESP_OKAY, 5'h00);
        add_step(OP_RD, P_PEND, 32'h0, 4'h0, 32'h0, RESP_OKAY, 5'h00);
        // Completed sources pend again when their lines return
        add_step(OP_WAIT_EXT, 32'h0, 32'h0, 4'h0, 32'h1, RESP_OKAY, 5'h0A);
        add_step(OP_RD, P_PEND, 32'h0, 4'h0, 32'h0A, RESP_OKAY, 5'h00);
    endtask

    // ============================================================
    // RAM responder model
    // ============================================================

    initial begin
        int        delay;
        int        n;
        lite_req_t held;
        ram_req_ready = 1'b0;
        ram_rsp_valid = 1'b0;
        ram_rsp       = '0;
        ram_count     = 0;
        ram_seen      = '0;
        forever begin
            @(negedge clk);
            if (ram_req_valid) begin
                // Random accept delay
                draw_bits(2, delay);
                repeat (delay + 1) @(posedge clk);
                ram_req_ready <= 1'b1;
                @(negedge clk);
                held = ram_req;
                @(posedge clk);
                ram_req_ready <= 1'b0;
                ram_seen = held;
                ram_count++;
                // Random response delay
                draw_bits(3, delay);
                repeat (delay + 1) @(posedge clk);
                ram_rsp_valid <= 1'b1;
                ram_rsp <= '{rdata: held.write ? 32'h0 : held.addr ^ RAM_XOR, resp: RESP_OKAY};
                n = 0;
                do begin
                    @(negedge clk);
                    n++;
                end while (!ram_rsp_ready && n < WAIT_LIMIT);
                if (!ram_rsp_ready) begin
                    timeouts++;
                    $display("Timeout: RAM response was never taken by the harness");
                end else begin
                    @(posedge clk);
                end
                ram_rsp_valid <= 1'b0;
            end
        end
    end

    // ============================================================
    // Master side
    // ============================================================

    task automatic run_access(input step_t s);
        int        n;
        int        stall;
        int        ram_before;
        lite_rsp_t held;
        @(posedge clk);
        irq_in        <= s.irq;
        cpu_req_valid <= 1'b1;
        cpu_req       <= '{addr: s.addr, wdata: s.wdata, wstrb: s.wstrb, write: s.op == OP_WR};
        ram_before    = ram_count;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_req_ready && n < WAIT_LIMIT);
        if (!cpu_req_ready) begin
            timeouts++;
            $display("Timeout: request to %h was never accepted", s.addr);
            return;
        end
        @(posedge clk);
        cpu_req_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_rsp_valid && n < WAIT_LIMIT);
        if (!cpu_rsp_valid) begin
            timeouts++;
            $display("Timeout: no response for access to %h", s.addr);
            return;
        end
        // Hold off the response, it must not move
        held = cpu_rsp;
        draw_bits(2, stall);
        for (int k = 0; k < stall; k++) begin
            @(posedge clk);
            @(negedge clk);
            compare_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'd1);
            compare_value("cpu_req_ready", 32'(cpu_req_ready), 32'd0);
            compare_value("ram_rsp_ready", 32'(ram_rsp_ready), 32'd0);
            compare_value("cpu_rsp.rdata", cpu_rsp.rdata, held.rdata);
            compare_value("cpu_rsp.resp", 32'(cpu_rsp.resp), 32'(held.resp));
        end
        @(posedge clk);
        cpu_rsp_ready <= 1'b1;
        @(negedge clk);
        compare_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'd1);
        compare_value("cpu_rsp.rdata", cpu_rsp.rdata, s.exp_rdata);
        compare_value("cpu_rsp.resp", 32'(cpu_rsp.resp), 32'(s.exp_resp));
        @(posedge clk);
        cpu_rsp_ready <= 1'b0;
        // RAM sees exactly the master's access, or nothing
        if (maps_to_ram(s.addr)) begin
            compare_value("ram request count", ram_count - ram_before, 32'd1);
            compare_value("ram_req.addr", ram_seen.addr, s.addr);
            compare_value("ram_req.wdata", ram_seen.wdata, s.wdata);
            compare_value("ram_req.wstrb", 32'(ram_seen.wstrb), 32'(s.wstrb));
            compare_value("ram_req.write", 32'(ram_seen.write), 32'(s.op == OP_WR));
        end else begin
            compare_value("ram request count", ram_count - ram_before, 32'd0);
        end
    endtask

    task automatic wait_level(input step_t s);
        int   n;
        logic level;
        @(posedge clk);
        irq_in <= s.irq;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            level = irq_level(s.op);
        end while (level !== s.exp_rdata[0] && n < WAIT_LIMIT);
        if (level !== s.exp_rdata[0]) begin
            timeouts++;
            $display("Timeout: %s never saw level %0b", s.op.name(), s.exp_rdata[0]);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        irq_in        = '0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        cpu_rsp_ready = 1'b0;
        errors        = 0;
        timeouts      = 0;
        build_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        // Quiet outputs after reset
        compare_value("timer_irq", 32'(timer_irq), 32'd0);
        compare_value("soft_irq", 32'(soft_irq), 32'd0);
        compare_value("ext_irq", 32'(ext_irq), 32'd0);
        compare_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'd0);
        compare_value("ram_req_valid", 32'(ram_req_valid), 32'd0);
        compare_value("ram_rsp_ready", 32'(ram_rsp_ready), 32'd0);
        compare_value("cpu_req_ready", 32'(cpu_req_ready), 32'd1);
        foreach (steps[i]) begin
            // Stop applying after the first hang
            if (timeouts == 0) begin
                if (steps[i].op == OP_RD || steps[i].op == OP_WR) begin
                    run_access(steps[i]);
                end else begin
                    wait_level(steps[i]);
                end
            end
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: periph_harness.f
common/periph_pkg.sv
xbar/lite_xbar.sv
clint/irq_clint.sv
plic/irq_plic.sv
src/periph_harness.sv
bench/periph_harness_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the peripheral harness regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f periph_harness.f \
    --top-module periph_harness_tb \
    --Mdir obj_dir -o periph_harness_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/periph_harness_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
